/* Makefile */
SOURCES = core_params.svh rv_isa_pkg.sv core_pkg.sv fetch_unit.sv inst_decoder.sv \
	register_file.sv exec_unit.sv lsu.sv rv_core_top.sv tb_core.sv

.PHONY: all run clean

all: obj_dir/Vtb_core

obj_dir/Vtb_core: src.f $(SOURCES)
	verilator --binary --timing --top-module tb_core -f src.f

run: obj_dir/Vtb_core
	./obj_dir/Vtb_core | awk '{ print } /^sim passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath width and register file geometry
`define XLEN       32
`define NUM_REGS   32
`define REG_ADDR_W 5

// first fetch address out of reset
`define RESET_PC   32'h8000_0000

`endif

/* core_pkg.sv */
`default_nettype none

`include "core_params.svh"

package core_pkg;

  typedef logic [`XLEN-1:0]       word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [3:0]             byte_mask_t; // one bit per byte lane

  // register write-back source
  typedef enum logic [1:0] {
    WB_ALU  = 2'd0, // adder result
    WB_LINK = 2'd1, // pc + 4 for jal/jalr
    WB_LOAD = 2'd2
  } wb_sel_t;

  // first adder operand
  typedef enum logic {
    A1_RS1 = 1'b0,
    A1_PC  = 1'b1
  } a1_sel_t;

endpackage

`default_nettype wire

/* exec_unit.sv */
`default_nettype none

`include "core_params.svh"

module exec_unit (
  input  wire core_pkg::word_t   pc,
  input  wire core_pkg::word_t   rs1_data,
  input  wire core_pkg::word_t   imm,
  input  wire core_pkg::a1_sel_t a1_sel,
  input  wire core_pkg::wb_sel_t wb_sel,
  input  wire core_pkg::word_t   load_data,
  output core_pkg::word_t        sum,
  output core_pkg::word_t        wb_data
);

  core_pkg::word_t a1;
  core_pkg::word_t link;

  assign a1   = (a1_sel == core_pkg::A1_PC) ? pc : rs1_data;
  assign sum  = a1 + imm; // result, jump target and mem address
  assign link = pc + `XLEN'(4);

  always_comb begin
    case (wb_sel)
      core_pkg::WB_LINK: wb_data = link;
      core_pkg::WB_LOAD: wb_data = load_data;
      default:           wb_data = sum;
    endcase
  end

endmodule

`default_nettype wire

/* fetch_unit.sv */
`default_nettype none

`include "core_params.svh"

module fetch_unit (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            jump,
  input  wire core_pkg::word_t jump_target,
  input  wire logic            is_ebreak,
  output core_pkg::word_t      pc,
  output logic                 halted
);

  core_pkg::word_t pc_next;

  always_comb begin
    if (halted) begin
      pc_next = pc; // frozen until reset
    end else if (jump) begin
      pc_next = {jump_target[`XLEN-1:1], 1'b0}; // jalr clears bit 0
    end else begin
      pc_next = pc + `XLEN'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= `RESET_PC;
      halted <= 1'b0;
    end else begin
      pc <= pc_next;
      if (is_ebreak) begin
        halted <= 1'b1; // sticky
      end
    end
  end

endmodule

`default_nettype wire

/* inst_decoder.sv */
`default_nettype none

module inst_decoder (
  input  wire rv_isa_pkg::inst_t inst,
  output core_pkg::reg_addr_t    rs1,
  output core_pkg::reg_addr_t    rs2,
  output core_pkg::reg_addr_t    rd,
  output core_pkg::word_t        imm,
  output core_pkg::a1_sel_t      a1_sel,
  output core_pkg::wb_sel_t      wb_sel,
  output logic                   reg_we,
  output logic                   jump,
  output logic                   mem_load,
  output logic                   mem_store,
  output logic                   is_ebreak,
  output rv_isa_pkg::funct3_t    funct3
);

  rv_isa_pkg::opcode_t opcode;
  core_pkg::word_t     imm_i;
  core_pkg::word_t     imm_s;
  core_pkg::word_t     imm_u;
  core_pkg::word_t     imm_j;

  assign opcode = rv_isa_pkg::opcode_t'(inst[6:0]);
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs2    = inst[24:20]; // store source

  // lui reads x0 so the adder passes the immediate through
  assign rs1 = (opcode == rv_isa_pkg::LUI) ? '0 : inst[19:15];

  // sign-extended immediates
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    imm       = imm_i;
    a1_sel    = core_pkg::A1_RS1;
    wb_sel    = core_pkg::WB_ALU;
    reg_we    = 1'b0;
    jump      = 1'b0;
    mem_load  = 1'b0;
    mem_store = 1'b0;
    is_ebreak = 1'b0;
    case (opcode)
      rv_isa_pkg::OP_IMM: begin
        reg_we = 1'b1; // funct3 ignored, always addi
      end
      rv_isa_pkg::AUIPC: begin
        imm    = imm_u;
        a1_sel = core_pkg::A1_PC;
        reg_we = 1'b1;
      end
      rv_isa_pkg::LUI: begin
        imm    = imm_u;
        reg_we = 1'b1;
      end
      rv_isa_pkg::JAL: begin
        imm    = imm_j;
        a1_sel = core_pkg::A1_PC;
        wb_sel = core_pkg::WB_LINK;
        reg_we = 1'b1;
        jump   = 1'b1;
      end
      rv_isa_pkg::JALR: begin
        wb_sel = core_pkg::WB_LINK;
        reg_we = 1'b1;
        jump   = 1'b1;
      end
      rv_isa_pkg::LOAD: begin
        wb_sel   = core_pkg::WB_LOAD;
        reg_we   = 1'b1;
        mem_load = 1'b1;
      end
      rv_isa_pkg::STORE: begin
        imm       = imm_s;
        mem_store = 1'b1;
      end
      rv_isa_pkg::SYSTEM: begin
        is_ebreak = (inst == rv_isa_pkg::EBREAK_INST);
      end
      default: ; // unsupported, pc + 4 and no writes
    endcase
  end

endmodule

`default_nettype wire

/* lsu.sv */
`default_nettype none

`include "core_params.svh"

module lsu (
  input  wire logic                reset,
  input  wire logic                load,
  input  wire logic                store,
  input  wire logic                halted,
  input  wire rv_isa_pkg::funct3_t funct3,
  input  wire core_pkg::word_t     addr,
  input  wire core_pkg::word_t     store_src,
  input  wire core_pkg::word_t     mem_rdata,
  output core_pkg::word_t          mem_addr,
  output logic                     mem_re,
  output logic                     mem_we,
  output core_pkg::word_t          mem_wdata,
  output core_pkg::byte_mask_t     mem_wmask,
  output core_pkg::word_t          load_data
);

  logic [1:0]           offset;
  logic                 aligned;
  core_pkg::byte_mask_t width_mask;
  core_pkg::word_t      st_shifted;
  core_pkg::word_t      ld_shifted;
  core_pkg::word_t      ld_ext;

  assign offset   = addr[1:0];
  assign mem_addr = {addr[`XLEN-1:2], 2'b00}; // word aligned
  assign mem_re   = load;

  // access width and natural alignment
  always_comb begin
    case (funct3)
      rv_isa_pkg::F3_B, rv_isa_pkg::F3_BU: begin
        width_mask = 4'b0001;
        aligned    = 1'b1;
      end
      rv_isa_pkg::F3_H, rv_isa_pkg::F3_HU: begin
        width_mask = 4'b0011;
        aligned    = ~offset[0];
      end
      rv_isa_pkg::F3_W: begin
        width_mask = 4'b1111;
        aligned    = (offset == 2'b00);
      end
      default: begin
        width_mask = 4'b0000;
        aligned    = 1'b0;
      end
    endcase
  end

  // stores only know b/h/w, unsigned widths write nothing
  assign mem_wmask = (store && aligned && !funct3[2]) ? (width_mask << offset) : '0;
  assign mem_we    = store && (mem_wmask != '0) && !halted && !reset;

  assign st_shifted = store_src << {offset, 3'b000};

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      mem_wdata[8*i +: 8] = mem_wmask[i] ? st_shifted[8*i +: 8] : 8'h00; // unused lanes zero
    end
  end

  // bring the addressed lane down to bit 0
  assign ld_shifted = mem_rdata >> {offset, 3'b000};

  always_comb begin
    case (funct3)
      rv_isa_pkg::F3_B:  ld_ext = {{24{ld_shifted[7]}}, ld_shifted[7:0]};
      rv_isa_pkg::F3_H:  ld_ext = {{16{ld_shifted[15]}}, ld_shifted[15:0]};
      rv_isa_pkg::F3_W:  ld_ext = ld_shifted;
      rv_isa_pkg::F3_BU: ld_ext = {24'h00_0000, ld_shifted[7:0]};
      rv_isa_pkg::F3_HU: ld_ext = {16'h0000, ld_shifted[15:0]};
      default:           ld_ext = '0;
    endcase
  end

  assign load_data = (load && aligned) ? ld_ext : '0; // misaligned reads back zero

endmodule

`default_nettype wire

/* register_file.sv */
`default_nettype none

`include "core_params.svh"

module register_file (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                halted,
  input  wire logic                we,
  input  wire core_pkg::reg_addr_t waddr,
  input  wire core_pkg::word_t     wdata,
  input  wire core_pkg::reg_addr_t raddr1,
  input  wire core_pkg::reg_addr_t raddr2,
  output core_pkg::word_t          rdata1,
  output core_pkg::word_t          rdata2
);

  core_pkg::word_t regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && !halted && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 reads as zero
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* rv_core_top.sv */
`default_nettype none

module rv_core_top (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire rv_isa_pkg::inst_t inst,
  output core_pkg::word_t        pc,
  output core_pkg::word_t        dmem_addr,
  output core_pkg::word_t        dmem_wdata,
  output logic                   dmem_re,
  output logic                   dmem_we,
  output core_pkg::byte_mask_t   dmem_wmask,
  input  wire core_pkg::word_t   dmem_rdata,
  output logic                   halt
);

  core_pkg::reg_addr_t rs1;
  core_pkg::reg_addr_t rs2;
  core_pkg::reg_addr_t rd;
  core_pkg::word_t     imm;
  core_pkg::word_t     rs1_data;
  core_pkg::word_t     rs2_data;
  core_pkg::word_t     sum;
  core_pkg::word_t     wb_data;
  core_pkg::word_t     load_data;
  core_pkg::a1_sel_t   a1_sel;
  core_pkg::wb_sel_t   wb_sel;
  rv_isa_pkg::funct3_t funct3;
  logic                reg_we;
  logic                jump;
  logic                mem_load;
  logic                mem_store;
  logic                is_ebreak;

  fetch_unit fetch (
    .clk(clk), .reset(reset), .jump(jump), .jump_target(sum),
    .is_ebreak(is_ebreak), .pc(pc), .halted(halt)
  );

  inst_decoder decode (
    .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .a1_sel(a1_sel), .wb_sel(wb_sel), .reg_we(reg_we), .jump(jump),
    .mem_load(mem_load), .mem_store(mem_store), .is_ebreak(is_ebreak),
    .funct3(funct3)
  );

  register_file regs (
    .clk(clk), .reset(reset), .halted(halt), .we(reg_we), .waddr(rd),
    .wdata(wb_data), .raddr1(rs1), .raddr2(rs2),
    .rdata1(rs1_data), .rdata2(rs2_data)
  );

  exec_unit exec (
    .pc(pc), .rs1_data(rs1_data), .imm(imm), .a1_sel(a1_sel),
    .wb_sel(wb_sel), .load_data(load_data), .sum(sum), .wb_data(wb_data)
  );

  lsu ldst (
    .reset(reset), .load(mem_load), .store(mem_store), .halted(halt),
    .funct3(funct3), .addr(sum), .store_src(rs2_data), .mem_rdata(dmem_rdata),
    .mem_addr(dmem_addr), .mem_re(dmem_re), .mem_we(dmem_we),
    .mem_wdata(dmem_wdata), .mem_wmask(dmem_wmask), .load_data(load_data)
  );

endmodule

`default_nettype wire

/* rv_isa_pkg.sv */
`default_nettype none

`include "core_params.svh"

package rv_isa_pkg;

  typedef logic [`XLEN-1:0] inst_t;
  typedef logic [2:0]       funct3_t;

  // only the opcodes this core executes
  typedef enum logic [6:0] {
    OP_IMM = 7'b001_0011, // executed as addi
    AUIPC  = 7'b001_0111,
    LUI    = 7'b011_0111,
    JAL    = 7'b110_1111,
    JALR   = 7'b110_0111,
    LOAD   = 7'b000_0011,
    STORE  = 7'b010_0011,
    SYSTEM = 7'b111_0011
  } opcode_t;

  // load/store access width in funct3
  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

  // full encoding, other SYSTEM words are ignored
  localparam inst_t EBREAK_INST = 32'h0010_0073;

endpackage

`default_nettype wire

/* src.f */
+incdir+.
rv_isa_pkg.sv
core_pkg.sv
fetch_unit.sv
inst_decoder.sv
register_file.sv
exec_unit.sv
lsu.sv
rv_core_top.sv
tb_core.sv

/* tb_core.sv */
`default_nettype none

`include "core_params.svh"

module tb_core;

  localparam int CLK_PERIOD    = 10;
  localparam int RESET_CYCLES  = 10;
  localparam int PROG_LEN      = 200;          // ebreak goes right after
  localparam int DUMP_AT       = PROG_LEN - 29; // sw of x1..x29 closes the program
  localparam int DRAIN_CYCLES  = 10;
  localparam int WATCHDOG_TIME = (PROG_LEN + RESET_CYCLES + 20) * CLK_PERIOD;

  logic                 clk;
  logic                 reset;
  rv_isa_pkg::inst_t    inst;
  core_pkg::word_t      pc;
  core_pkg::word_t      dmem_addr;
  core_pkg::word_t      dmem_wdata;
  core_pkg::word_t      dmem_rdata;
  logic                 dmem_re;
  logic                 dmem_we;
  core_pkg::byte_mask_t dmem_wmask;
  logic                 halt;

  // program from word 0, data window at byte 0x380
  core_pkg::word_t      mem [256];
  core_pkg::word_t      ref_mem [256];
  core_pkg::word_t      ref_regs [`NUM_REGS];
  core_pkg::word_t      ref_pc;
  logic                 ref_halt;
  logic                 model_halted;
  logic                 exp_we;
  logic                 exp_re;
  core_pkg::byte_mask_t exp_mask;
  core_pkg::word_t      exp_addr;
  core_pkg::word_t      exp_wdata;
  logic [31:0]          rng;
  logic [7:0]           wp;  // program write pointer
  int                   checks;
  int                   word_errors;
  int                   mask_errors;
  int                   flag_errors;

  rv_core_top rv_core_top_i (
    .clk(clk), .reset(reset), .inst(inst), .pc(pc),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_re(dmem_re),
    .dmem_we(dmem_we), .dmem_wmask(dmem_wmask), .dmem_rdata(dmem_rdata),
    .halt(halt)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic core_pkg::word_t fill_word(logic [7:0] a);
    return {a ^ 8'ha5, ~a, a + 8'h3c, a[3:0], a[7:4]};
  endfunction

  function automatic core_pkg::word_t lane_bits(core_pkg::byte_mask_t m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  function automatic core_pkg::word_t merge_lanes(core_pkg::word_t old, core_pkg::word_t data,
                                                  core_pkg::byte_mask_t m);
    return (old & ~lane_bits(m)) | (data & lane_bits(m));
  endfunction

  // instruction encoders
  function automatic rv_isa_pkg::inst_t i_word(logic [6:0] op, logic [4:0] rd, logic [2:0] f3,
                                               logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_isa_pkg::inst_t s_word(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                               logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic rv_isa_pkg::inst_t u_word(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic rv_isa_pkg::inst_t j_word(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic emit(rv_isa_pkg::inst_t w);
    ref_mem[wp] = w;
    wp = wp + 8'd1;
  endtask

  task automatic build_program();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [4:0]  k;
    wp = 8'd0;
    emit(u_word(7'h37, 5'd30, 20'h80000));            // x30 = data window base
    emit(i_word(7'h13, 5'd30, 3'd0, 5'd30, 12'h380));
    while (wp < 8'(DUMP_AT - 3)) begin
      r  = xorshift();
      rd = r[12:8] % 5'd30; // x30 and x31 stay reserved
      case (r[2:0])
        3'd0: emit(i_word(7'h13, rd, 3'd0, r[17:13], r[29:18]));
        3'd1: emit(u_word(7'h37, rd, r[31:12]));
        3'd2: emit(u_word(7'h17, rd, r[31:12]));
        3'd3: emit(s_word(r[15:13] % 3'd3, 5'd30, r[20:16], {5'd0, r[27:21]}));
        3'd4: begin
          f3 = r[15:13];
          if (f3 == 3'd3 || f3 > 3'd5) f3 = 3'd2;
          emit(i_word(7'h03, rd, f3, 5'd30, {5'd0, r[27:21]}));
        end
        3'd5: begin
          emit(j_word(rd, r[13] ? 21'd8 : 21'd4));
          if (r[13]) emit(i_word(7'h13, rd, 3'd0, rd, 12'h555)); // skipped
        end
        3'd6: begin
          emit(u_word(7'h17, 5'd31, 20'h0));
          emit(i_word(7'h67, rd, 3'd0, 5'd31, 12'd8 | {9'd0, r[14], 1'b0, r[13]}));
          if (r[14]) emit(i_word(7'h13, rd, 3'd0, rd, 12'h555));
        end
        default: emit({r[31:7], 7'h33}); // R-type, not executed
      endcase
    end
    while (wp < 8'(DUMP_AT)) emit(i_word(7'h13, 5'd0, 3'd0, 5'd0, 12'd0));
    for (k = 5'd1; k < 5'd30; k = k + 5'd1) begin
      emit(s_word(3'd2, 5'd30, k, {5'd0, k - 5'd1, 2'b00}));
    end
    emit(32'h0010_0073); // ebreak
    emit(s_word(3'd2, 5'd30, 5'd1, 12'd0)); // sits past the ebreak, never commits
  endtask

  function automatic void set_reg(logic [4:0] rd, core_pkg::word_t v);
    if (rd != 5'd0) ref_regs[rd] = v;
  endfunction

  // ISA model that retires one instruction and sets the expected port values
  function automatic void ref_step();
    rv_isa_pkg::inst_t w;
    core_pkg::word_t   v1;
    core_pkg::word_t   v2;
    core_pkg::word_t   imm_i;
    core_pkg::word_t   imm_s;
    core_pkg::word_t   a;
    core_pkg::word_t   lane;
    core_pkg::word_t   res;
    core_pkg::word_t   nxt;
    logic [1:0]        ofs;
    exp_we    = 1'b0;
    exp_re    = 1'b0;
    exp_mask  = '0;
    exp_wdata = '0;
    exp_addr  = '0;
    if (ref_halt) return;
    w     = ref_mem[ref_pc[9:2]];
    v1    = ref_regs[w[19:15]];
    v2    = ref_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    nxt   = ref_pc + 32'd4;
    case (w[6:0])
      7'h13: set_reg(w[11:7], v1 + imm_i);
      7'h37: set_reg(w[11:7], {w[31:12], 12'h000});
      7'h17: set_reg(w[11:7], ref_pc + {w[31:12], 12'h000});
      7'h6f: begin
        set_reg(w[11:7], ref_pc + 32'd4);
        nxt = ref_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      7'h67: begin
        set_reg(w[11:7], ref_pc + 32'd4);
        nxt = (v1 + imm_i) & ~32'd1;
      end
      7'h03: begin
        a        = v1 + imm_i;
        ofs      = a[1:0];
        exp_re   = 1'b1;
        exp_addr = {a[31:2], 2'b00};
        lane     = ref_mem[a[9:2]] >> {ofs, 3'b000};
        case (w[14:12])
          3'd0:    res = {{24{lane[7]}}, lane[7:0]};
          3'd1:    res = ofs[0] ? '0 : {{16{lane[15]}}, lane[15:0]};
          3'd2:    res = (ofs != 2'd0) ? '0 : lane;
          3'd4:    res = {24'h00_0000, lane[7:0]};
          3'd5:    res = ofs[0] ? '0 : {16'h0000, lane[15:0]};
          default: res = '0;
        endcase
        set_reg(w[11:7], res);
      end
      7'h23: begin
        a        = v1 + imm_s;
        ofs      = a[1:0];
        exp_addr = {a[31:2], 2'b00};
        case (w[14:12])
          3'd0:    exp_mask = 4'b0001 << ofs;
          3'd1:    exp_mask = ofs[0] ? 4'b0000 : (4'b0011 << ofs);
          3'd2:    exp_mask = (ofs == 2'd0) ? 4'b1111 : 4'b0000;
          default: exp_mask = 4'b0000;
        endcase
        exp_we    = (exp_mask != 4'b0000);
        exp_wdata = (v2 << {ofs, 3'b000}) & lane_bits(exp_mask);
        if (exp_we) ref_mem[a[9:2]] = merge_lanes(ref_mem[a[9:2]], exp_wdata, exp_mask);
      end
      7'h73: if (w == 32'h0010_0073) ref_halt = 1'b1;
      default: ; // anything else only moves on
    endcase
    ref_pc = nxt;
  endfunction

  task automatic check_word(string name, core_pkg::word_t got, core_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      word_errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_mask(string name, core_pkg::byte_mask_t got, core_pkg::byte_mask_t exp);
    checks++;
    if (got !== exp) begin
      mask_errors++;
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      flag_errors++;
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // data memory answers in the same cycle, writes land on the edge
  assign inst       = mem[pc[9:2]];
  assign dmem_rdata = dmem_re ? mem[dmem_addr[9:2]] : '0;

  always @(posedge clk) begin
    if (dmem_we) begin
      mem[dmem_addr[9:2]] <= merge_lanes(mem[dmem_addr[9:2]], dmem_wdata, dmem_wmask);
    end
  end

  // compare at the falling edge, away from the updates
  always @(negedge clk) begin
    if (reset) begin
      check_flag("dmem_we", dmem_we, 1'b0);
    end else begin
      check_word("pc", pc, ref_pc);
      check_flag("halt", halt, ref_halt);
      model_halted = ref_halt;
      ref_step();
      check_flag("dmem_we", dmem_we, exp_we);
      if (exp_we) begin
        check_word("dmem_addr", dmem_addr, exp_addr);
        check_word("dmem_wdata", dmem_wdata, exp_wdata);
        check_mask("dmem_wmask", dmem_wmask, exp_mask);
      end
      if (!model_halted) begin // re follows whatever word sits past the ebreak
        check_flag("dmem_re", dmem_re, exp_re);
        if (exp_re) check_word("dmem_addr", dmem_addr, exp_addr);
      end
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("timeout: the core did not halt within %0d time units", WATCHDOG_TIME);
    $display("sim failed");
    $finish;
  end

  initial begin
    reset       = 1'b1;
    rng         = 32'h274b_4628;
    checks      = 0;
    word_errors = 0;
    mask_errors = 0;
    flag_errors = 0;
    ref_pc      = `RESET_PC;
    ref_halt    = 1'b0;
    for (int i = 0; i < `NUM_REGS; i++) ref_regs[i[4:0]] = '0;
    for (int i = 0; i < 256; i++) ref_mem[i[7:0]] = fill_word(i[7:0]);
    build_program();
    for (int i = 0; i < 256; i++) mem[i[7:0]] <= ref_mem[i[7:0]];
    mem[0] <= s_word(3'd2, 5'd0, 5'd0, 12'd0); // sw x0 at the reset pc while reset holds
    repeat (RESET_CYCLES) @(posedge clk);
    reset  <= 1'b0;
    mem[0] <= ref_mem[0];
    @(posedge clk);
    while (halt !== 1'b1) @(negedge clk);
    repeat (DRAIN_CYCLES) @(posedge clk); // dmem_we must stay low while halted
    $display("checks %0d, word errors %0d, mask errors %0d, flag errors %0d",
             checks, word_errors, mask_errors, flag_errors);
    if (word_errors + mask_errors + flag_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
